// File: include/commit_defines.svh
/*
 * widths and sizes shared by the retirement stage
 * ROB_DEPTH must be a power of two of 2 or more, ROB_IDX_LEN its log2
 */
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// datapath and instruction widths
`define XLEN            32
`define ILEN            32
`define REG_IDX_LEN     5

// reorder buffer size
`define ROB_DEPTH       8
`define ROB_IDX_LEN     3

// riscv major opcodes, instr[6:0]
`define OPCODE_LEN      7
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LOAD        7'b0000011
`define OPC_LOAD_FP     7'b0000111
`define OPC_OP_FP       7'b1010011
`define OPC_STORE       7'b0100011
`define OPC_STORE_FP    7'b0100111

`endif

// File: verilog/commit_pkg.sv
/*
 * types of the retirement stage
 * exception codes follow the low mcause values, E_UNKNOWN is the reset code
 */
`default_nettype none

`include "commit_defines.svh"

package commit_pkg;

    // exception causes, 4 bits wide
    typedef enum logic [3:0] {
        E_INSTR_ADDR_MISALIGN = 4'd0,
        E_ILLEGAL_INSTR       = 4'd2,
        E_BREAKPOINT          = 4'd3,
        E_LD_ADDR_MISALIGN    = 4'd4,
        E_ST_ADDR_MISALIGN    = 4'd6,
        E_ECALL               = 4'd8,
        E_UNKNOWN             = 4'd15
    } except_code_t;

    // except view of the value word
    // code sits in the low bits, rest is padding
    typedef struct packed {
        logic [`XLEN-5:0] pad;
        except_code_t     code;
    } rob_except_view_t;

    // value field of a rob entry
    // except_raised selects the view
    typedef union packed {
        logic [`XLEN-1:0] data;
        rob_except_view_t except;
    } rob_value_u;

    typedef struct packed {
        logic [`ILEN-1:0]        instr;
        logic [`XLEN-1:0]        pc;
        logic [`REG_IDX_LEN-1:0] rd_idx;
        rob_value_u              value;
        logic                    except_raised;
    } rob_entry_t;

    // what retiring the head does
    typedef enum logic [1:0] {
        CLS_INT_WB = 2'd0,
        CLS_FP_WB  = 2'd1,
        CLS_STORE  = 2'd2,
        CLS_NONE   = 2'd3
    } instr_class_t;

endpackage

`default_nettype wire

// File: verilog/rob_head_if.sv
/*
 * rob head towards the commit logic, pop and flush back
 * pop only while head_valid, flush wins over a write in the same cycle
 */
`default_nettype none
`timescale 1ns/10ps

interface rob_head_if import commit_pkg::*; ();

    // head entry, valid while the buffer is not empty
    logic       head_valid;
    rob_entry_t head_entry;

    // retire the head
    logic       pop;
    // drop every entry, at the next edge
    logic       flush;

    // buffer side
    modport rob (
        output head_valid,
        output head_entry,
        input  pop,
        input  flush
    );

    // commit side
    modport commit (
        input  head_valid,
        input  head_entry,
        output pop,
        output flush
    );

endinterface

`default_nettype wire

// File: verilog/commit_wb_if.sv
/*
 * register writes from the commit logic to the register file
 * no ready, a high enable always writes at the next edge
 */
`default_nettype none
`timescale 1ns/10ps

`include "commit_defines.svh"

interface commit_wb_if ();

    // one enable per bank, at most one high
    logic                    int_we;
    logic                    fp_we;
    // shared destination and value
    logic [`REG_IDX_LEN-1:0] rd_idx;
    logic [`XLEN-1:0]        value;

    modport commit (
        output int_we,
        output fp_we,
        output rd_idx,
        output value
    );

    modport rf (
        input  int_we,
        input  fp_we,
        input  rd_idx,
        input  value
    );

endinterface

`default_nettype wire

// File: verilog/reorder_buffer.sv
/*
 * in-order circular buffer of finished instructions
 * depth must be a power of two, pointers wrap naturally
 * not ready while full or while the head is being flushed
 */
`default_nettype none
`timescale 1ns/10ps

`include "commit_defines.svh"

module reorder_buffer import commit_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ins_valid_i,
    output logic                    ins_ready_o,
    input  logic [`ILEN-1:0]        ins_instr_i,
    input  logic [`XLEN-1:0]        ins_pc_i,
    input  logic [`REG_IDX_LEN-1:0] ins_rd_idx_i,
    input  logic [`XLEN-1:0]        ins_value_i,
    input  logic                    ins_except_i,
    input  except_code_t            ins_except_code_i,
    rob_head_if.rob                 head
);

    // entry storage, payload only
    rob_entry_t rob_mem [`ROB_DEPTH];

    logic [`ROB_IDX_LEN-1:0] head_ptr;
    logic [`ROB_IDX_LEN-1:0] tail_ptr;
    // one extra bit to tell full from empty
    logic [`ROB_IDX_LEN:0]   count;
    logic                    full;
    logic                    push;
    rob_entry_t              new_entry;

    assign full        = (count == (`ROB_IDX_LEN+1)'(`ROB_DEPTH));
    assign ins_ready_o = !full && !head.flush;
    assign push        = ins_valid_i && ins_ready_o;

    // pack the incoming entry
    always_comb begin
        new_entry.instr         = ins_instr_i;
        new_entry.pc            = ins_pc_i;
        new_entry.rd_idx        = ins_rd_idx_i;
        new_entry.except_raised = ins_except_i;
        if (ins_except_i) begin
            // except view, result is meaningless here
            new_entry.value.except.pad  = '0;
            new_entry.value.except.code = ins_except_code_i;
        end else begin
            new_entry.value.data = ins_value_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            rob_mem[tail_ptr] <= new_entry;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (head.flush) begin
            // drop the head and everything younger
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (head.pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (push && !head.pop) begin
                count <= count + 1'b1;
            end else if (!push && head.pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // oldest entry to the commit logic
    assign head.head_valid = (count != '0);
    assign head.head_entry = rob_mem[head_ptr];

endmodule

`default_nettype wire

// File: verilog/commit_decoder.sv
/*
 * classifies the head opcode, purely combinational
 * head validity and exceptions are checked by the commit logic
 */
`default_nettype none
`timescale 1ns/10ps

`include "commit_defines.svh"

module commit_decoder import commit_pkg::*; (
    input  logic [`ILEN-1:0] instr_i,
    input  logic             store_ready_i,
    output instr_class_t     class_o,
    output logic             comm_possible_o
);

    logic [`OPCODE_LEN-1:0] opcode;

    // major opcode in the low bits
    assign opcode = instr_i[`OPCODE_LEN-1:0];

    always_comb begin
        case (opcode)
            // integer results, loads included
            `OPC_OP, `OPC_OP_IMM, `OPC_LOAD: begin
                class_o = CLS_INT_WB;
            end
            // fp results
            `OPC_LOAD_FP, `OPC_OP_FP: begin
                class_o = CLS_FP_WB;
            end
            `OPC_STORE, `OPC_STORE_FP: begin
                class_o = CLS_STORE;
            end
            // branches, jumps, system and the rest retire without a write
            default: begin
                class_o = CLS_NONE;
            end
        endcase
    end

    // stores wait for the store buffer, all else goes at once
    assign comm_possible_o = !((class_o == CLS_STORE) && !store_ready_i);

endmodule

`default_nettype wire

// File: verilog/commit_logic.sv
/*
 * retires or traps the rob head, at most one per cycle
 * a trap flushes all younger entries and writes nothing
 * report outputs are registered one-cycle pulses
 */
`default_nettype none
`timescale 1ns/10ps

`include "commit_defines.svh"

module commit_logic import commit_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             store_ready_i,
    rob_head_if.commit       head,
    commit_wb_if.commit      wb,
    output logic             commit_o,
    output logic [`XLEN-1:0] commit_pc_o,
    output logic             store_commit_o,
    output logic             except_o,
    output except_code_t     except_code_o,
    output logic [`XLEN-1:0] except_pc_o
);

    instr_class_t head_class;
    logic         comm_possible;
    logic         do_retire;
    logic         do_trap;

    commit_decoder u_comm_decoder (
        .instr_i         (head.head_entry.instr),
        .store_ready_i   (store_ready_i),
        .class_o         (head_class),
        .comm_possible_o (comm_possible)
    );

    // faulting head, no condition to wait for
    assign do_trap   = head.head_valid && head.head_entry.except_raised;
    // clean head, once the decoder allows
    assign do_retire = head.head_valid && !head.head_entry.except_raised && comm_possible;

    assign head.pop   = do_retire || do_trap;
    assign head.flush = do_trap;

    // writeback, same edge as the pop
    assign wb.int_we = do_retire && (head_class == CLS_INT_WB);
    assign wb.fp_we  = do_retire && (head_class == CLS_FP_WB);
    assign wb.rd_idx = head.head_entry.rd_idx;
    // data view, valid only without exception
    assign wb.value  = head.head_entry.value.data;

    // report registers
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_o       <= 1'b0;
            commit_pc_o    <= '0;
            store_commit_o <= 1'b0;
            except_o       <= 1'b0;
            except_code_o  <= E_UNKNOWN;
            except_pc_o    <= '0;
        end else begin
            // pulses last one cycle
            commit_o       <= do_retire;
            store_commit_o <= do_retire && (head_class == CLS_STORE);
            except_o       <= do_trap;
            // pc and code hold until the next event
            if (do_retire) begin
                commit_pc_o <= head.head_entry.pc;
            end
            if (do_trap) begin
                except_pc_o   <= head.head_entry.pc;
                except_code_o <= head.head_entry.value.except.code;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/arch_regfile.sv
/*
 * integer and fp register banks, 32 each, one write per cycle
 * x0 ignores writes and reads as zero, fp register 0 is a normal one
 */
`default_nettype none
`timescale 1ns/10ps

`include "commit_defines.svh"

module arch_regfile (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    commit_wb_if.rf                 wb,
    input  logic [`REG_IDX_LEN-1:0] int_rd_addr_i,
    output logic [`XLEN-1:0]        int_rd_data_o,
    input  logic [`REG_IDX_LEN-1:0] fp_rd_addr_i,
    output logic [`XLEN-1:0]        fp_rd_data_o
);

    localparam int NUM_REGS = 1 << `REG_IDX_LEN;

    logic [`XLEN-1:0] int_regs [NUM_REGS];
    logic [`XLEN-1:0] fp_regs  [NUM_REGS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // both banks start at zero
            for (int i = 0; i < NUM_REGS; i++) begin
                int_regs[i] <= '0;
                fp_regs[i]  <= '0;
            end
        end else begin
            // x0 stays zero
            if (wb.int_we && (wb.rd_idx != '0)) begin
                int_regs[wb.rd_idx] <= wb.value;
            end
            if (wb.fp_we) begin
                fp_regs[wb.rd_idx] <= wb.value;
            end
        end
    end

    // combinational read ports
    assign int_rd_data_o = (int_rd_addr_i == '0) ? '0 : int_regs[int_rd_addr_i];
    assign fp_rd_data_o  = fp_regs[fp_rd_addr_i];

endmodule

`default_nettype wire

// File: verilog/commit_top.sv
/*
 * retirement stage: rob, commit logic and architectural register file
 * store_ready_i is a level, the store buffer itself lives outside
 */
`default_nettype none
`timescale 1ns/10ps

`include "commit_defines.svh"

module commit_top import commit_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // finished instructions, program order
    input  logic                    ins_valid_i,
    output logic                    ins_ready_o,
    input  logic [`ILEN-1:0]        ins_instr_i,
    input  logic [`XLEN-1:0]        ins_pc_i,
    input  logic [`REG_IDX_LEN-1:0] ins_rd_idx_i,
    input  logic [`XLEN-1:0]        ins_value_i,
    input  logic                    ins_except_i,
    input  except_code_t            ins_except_code_i,
    // store buffer can take a store
    input  logic                    store_ready_i,
    // commit report
    output logic                    commit_o,
    output logic [`XLEN-1:0]        commit_pc_o,
    output logic                    store_commit_o,
    output logic                    except_o,
    output except_code_t            except_code_o,
    output logic [`XLEN-1:0]        except_pc_o,
    // register read ports
    input  logic [`REG_IDX_LEN-1:0] int_rd_addr_i,
    output logic [`XLEN-1:0]        int_rd_data_o,
    input  logic [`REG_IDX_LEN-1:0] fp_rd_addr_i,
    output logic [`XLEN-1:0]        fp_rd_data_o
);

    rob_head_if  head_if ();
    commit_wb_if wb_if ();

    reorder_buffer u_rob (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .ins_valid_i       (ins_valid_i),
        .ins_ready_o       (ins_ready_o),
        .ins_instr_i       (ins_instr_i),
        .ins_pc_i          (ins_pc_i),
        .ins_rd_idx_i      (ins_rd_idx_i),
        .ins_value_i       (ins_value_i),
        .ins_except_i      (ins_except_i),
        .ins_except_code_i (ins_except_code_i),
        .head              (head_if.rob)
    );

    commit_logic u_commit (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .store_ready_i  (store_ready_i),
        .head           (head_if.commit),
        .wb             (wb_if.commit),
        .commit_o       (commit_o),
        .commit_pc_o    (commit_pc_o),
        .store_commit_o (store_commit_o),
        .except_o       (except_o),
        .except_code_o  (except_code_o),
        .except_pc_o    (except_pc_o)
    );

    arch_regfile u_rf (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .wb            (wb_if.rf),
        .int_rd_addr_i (int_rd_addr_i),
        .int_rd_data_o (int_rd_data_o),
        .fp_rd_addr_i  (fp_rd_addr_i),
        .fp_rd_data_o  (fp_rd_data_o)
    );

endmodule

`default_nettype wire

// File: verification/tb_commit_top.sv
/*
 * directed testbench for the retirement stage
 * a negedge monitor checks every report against an expected queue
 * and mirrors retired writes into a reference model of both banks
 */
`default_nettype none
`timescale 1ns/10ps

`include "commit_defines.svh"

module tb_commit_top import commit_pkg::*; ();

    localparam int NUM_REGS    = 1 << `REG_IDX_LEN;
    // about 40 instructions and 8 register sweeps over all tests
    localparam int NUM_INSTR   = 40;
    localparam int NUM_SWEEPS  = 8;
    localparam int CYCLE_LIMIT = NUM_INSTR * 10 + NUM_SWEEPS * (NUM_REGS + 8) + 100;

    // kinds of expected report
    localparam logic [2:0] K_INT   = 3'd0;
    localparam logic [2:0] K_FP    = 3'd1;
    localparam logic [2:0] K_STORE = 3'd2;
    localparam logic [2:0] K_EXC   = 3'd3;

    typedef struct packed {
        logic [2:0]              kind;
        logic [`XLEN-1:0]        pc;
        logic [`REG_IDX_LEN-1:0] rd;
        logic [`XLEN-1:0]        value;
        logic [3:0]              code;
    } report_t;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    ins_valid_i;
    logic                    ins_ready_o;
    logic [`ILEN-1:0]        ins_instr_i;
    logic [`XLEN-1:0]        ins_pc_i;
    logic [`REG_IDX_LEN-1:0] ins_rd_idx_i;
    logic [`XLEN-1:0]        ins_value_i;
    logic                    ins_except_i;
    except_code_t            ins_except_code_i;
    logic                    store_ready_i;
    logic                    commit_o;
    logic [`XLEN-1:0]        commit_pc_o;
    logic                    store_commit_o;
    logic                    except_o;
    except_code_t            except_code_o;
    logic [`XLEN-1:0]        except_pc_o;
    logic [`REG_IDX_LEN-1:0] int_rd_addr_i;
    logic [`XLEN-1:0]        int_rd_data_o;
    logic [`REG_IDX_LEN-1:0] fp_rd_addr_i;
    logic [`XLEN-1:0]        fp_rd_data_o;

    // reports still to come with the oldest in front
    report_t          exp_q [$];
    report_t          rec;
    logic [`XLEN-1:0] int_model [NUM_REGS];
    logic [`XLEN-1:0] fp_model  [NUM_REGS];
    logic [31:0]      rng_state;
    logic [`XLEN-1:0] next_pc;
    int               err_count;
    int               report_count;
    int               cycle_count;

    commit_top dut_i (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        err_count++;
    endtask

    // checks each report pulse and applies retired writes to the model
    always @(negedge clk_i) begin
        if (rst_n_i && (commit_o || except_o)) begin
            if (exp_q.size() == 0) begin
                flag_error($sformatf("unexpected report, commit_o=%b except_o=%b pc=%h",
                                     commit_o, except_o, commit_o ? commit_pc_o : except_pc_o));
            end else begin
                rec = exp_q.pop_front();
                report_count++;
                if (rec.kind == K_EXC) begin
                    if (!except_o || commit_o) begin
                        flag_error($sformatf("expected except_o for pc %h", rec.pc));
                    end else if (except_code_o !== rec.code || except_pc_o !== rec.pc) begin
                        flag_error($sformatf("except code %h pc %h, expected %h pc %h",
                                             except_code_o, except_pc_o, rec.code, rec.pc));
                    end
                end else if (!commit_o || except_o) begin
                    flag_error($sformatf("expected commit_o for pc %h", rec.pc));
                end else begin
                    if (commit_pc_o !== rec.pc) begin
                        flag_error($sformatf("commit pc %h, expected %h", commit_pc_o, rec.pc));
                    end
                    if (store_commit_o !== (rec.kind == K_STORE)) begin
                        flag_error($sformatf("store_commit_o=%b for pc %h",
                                             store_commit_o, rec.pc));
                    end
                    // x0 never changes
                    if (rec.kind == K_INT && rec.rd != '0) begin
                        int_model[rec.rd] = rec.value;
                    end
                    if (rec.kind == K_FP) begin
                        fp_model[rec.rd] = rec.value;
                    end
                end
            end
        end else if (rst_n_i && store_commit_o) begin
            flag_error("store_commit_o without commit_o");
        end
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycle_count);
            $display("errors: %0d, reports checked: %0d", err_count, report_count);
            $display("Verification failed");
            $finish;
        end
    end

    // offer one entry and wait for the transfer edge
    task automatic send_entry(input logic [6:0] opcode, input logic [2:0] kind,
                              input logic [4:0] rd, input logic exc,
                              input except_code_t code, input logic retires);
        report_t     r;
        logic [31:0] upper;
        upper = rand_word();
        @(negedge clk_i);
        ins_valid_i       = 1'b1;
        ins_instr_i       = {upper[31:7], opcode};
        ins_pc_i          = next_pc;
        ins_rd_idx_i      = rd;
        ins_value_i       = rand_word();
        ins_except_i      = exc;
        ins_except_code_i = code;
        while (!ins_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        if (retires) begin
            r.kind  = exc ? K_EXC : kind;
            r.pc    = ins_pc_i;
            r.rd    = rd;
            r.value = ins_value_i;
            r.code  = code;
            exp_q.push_back(r);
        end
        next_pc = next_pc + 4;
    endtask

    task automatic send_alu(input logic fp_bank, input logic [4:0] rd, input logic retires);
        logic [31:0] r;
        logic [6:0]  opcode;
        r = rand_word();
        if (fp_bank) begin
            opcode = r[0] ? `OPC_LOAD_FP : `OPC_OP_FP;
        end else begin
            opcode = (r[1:0] == 2'd0) ? `OPC_OP : (r[1:0] == 2'd1) ? `OPC_OP_IMM : `OPC_LOAD;
        end
        send_entry(opcode, fp_bank ? K_FP : K_INT, rd, 1'b0, E_UNKNOWN, retires);
    endtask

    task automatic send_store();
        logic [31:0] r;
        r = rand_word();
        send_entry(r[0] ? `OPC_STORE : `OPC_STORE_FP, K_STORE, r[8:4], 1'b0, E_UNKNOWN, 1'b1);
    endtask

    task automatic idle();
        @(negedge clk_i);
        ins_valid_i = 1'b0;
    endtask

    task automatic set_store_ready(input logic level);
        @(negedge clk_i);
        store_ready_i = level;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
    endtask

    // sweep both read ports against the model
    task automatic compare_all(input string tag);
        for (int i = 0; i < NUM_REGS; i++) begin
            @(negedge clk_i);
            int_rd_addr_i = 5'(i);
            fp_rd_addr_i  = 5'(i);
            #1;
            if (int_rd_data_o !== int_model[i]) begin
                flag_error($sformatf("%s: x%0d reads %h, expected %h",
                                     tag, i, int_rd_data_o, int_model[i]));
            end
            if (fp_rd_data_o !== fp_model[i]) begin
                flag_error($sformatf("%s: f%0d reads %h, expected %h",
                                     tag, i, fp_rd_data_o, fp_model[i]));
            end
        end
    endtask

    task automatic test_reset();
        if (ins_ready_o !== 1'b1 || commit_o !== 1'b0 || except_o !== 1'b0) begin
            flag_error("ready or report pulses wrong after reset");
        end
        if (store_commit_o !== 1'b0 || except_code_o !== E_UNKNOWN) begin
            flag_error("store_commit_o or except code wrong after reset");
        end
        if (commit_pc_o !== '0 || except_pc_o !== '0) begin
            flag_error("report pc not zero after reset");
        end
        compare_all("reset");
    endtask

    task automatic test_retire_order();
        logic [31:0] r;
        set_store_ready(1'b1);
        // x0 must keep reading zero
        send_alu(1'b0, 5'd0, 1'b1);
        for (int n = 0; n < 11; n++) begin
            r = rand_word();
            send_alu(r[5], r[4:0], 1'b1);
        end
        idle();
        wait_drain();
        compare_all("retire order");
    endtask

    task automatic test_store_stall();
        int reports_before;
        set_store_ready(1'b0);
        send_store();
        send_alu(1'b0, 5'd5, 1'b1);
        send_alu(1'b1, 5'd6, 1'b1);
        send_alu(1'b0, 5'd7, 1'b1);
        idle();
        reports_before = report_count;
        repeat (2 * `ROB_DEPTH) @(negedge clk_i);
        if (report_count != reports_before || exp_q.size() != 4) begin
            flag_error("entries retired while the store was stalled");
        end
        // younger writes must not be visible yet
        compare_all("store stalled");
        set_store_ready(1'b1);
        wait_drain();
        compare_all("store released");
    endtask

    task automatic test_exception();
        // stalled store keeps the trap and its younger entries queued
        set_store_ready(1'b0);
        send_store();
        send_entry(`OPC_LOAD, K_EXC, 5'd8, 1'b1, E_LD_ADDR_MISALIGN, 1'b1);
        send_alu(1'b0, 5'd9, 1'b0);
        send_alu(1'b1, 5'd10, 1'b0);
        idle();
        set_store_ready(1'b1);
        wait_drain();
        compare_all("younger flushed");
        // ready drops while a lone trap sits at the head
        send_entry(7'b1110011, K_EXC, 5'd0, 1'b1, E_ECALL, 1'b1);
        idle();
        if (ins_ready_o !== 1'b0) begin
            flag_error("ins_ready_o high while a trap flushes the buffer");
        end
        for (int n = 0; n < 4; n++) begin
            send_alu(n[0], 5'(n + 11), 1'b1);
        end
        idle();
        wait_drain();
        compare_all("after trap");
    endtask

    task automatic test_full();
        logic [31:0] r;
        set_store_ready(1'b0);
        send_store();
        for (int n = 1; n < `ROB_DEPTH; n++) begin
            r = rand_word();
            send_alu(r[5], r[4:0], 1'b1);
        end
        // one more offer that must not be taken while full
        @(negedge clk_i);
        ins_pc_i = next_pc;
        repeat (3) begin
            if (ins_ready_o !== 1'b0) begin
                flag_error("ins_ready_o high with a full buffer");
            end
            @(negedge clk_i);
        end
        ins_valid_i   = 1'b0;
        store_ready_i = 1'b1;
        wait_drain();
        compare_all("full buffer drained");
    endtask

    initial begin
        clk_i             = 1'b0;
        rst_n_i           = 1'b0;
        ins_valid_i       = 1'b0;
        ins_instr_i       = '0;
        ins_pc_i          = '0;
        ins_rd_idx_i      = '0;
        ins_value_i       = '0;
        ins_except_i      = 1'b0;
        ins_except_code_i = E_UNKNOWN;
        store_ready_i     = 1'b1;
        int_rd_addr_i     = '0;
        fp_rd_addr_i      = '0;
        rng_state         = 32'd13200;
        next_pc           = 32'h0000_1000;
        err_count         = 0;
        report_count      = 0;
        cycle_count       = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            int_model[i] = '0;
            fp_model[i]  = '0;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        test_reset();
        test_retire_order();
        test_store_stall();
        test_exception();
        test_full();

        if (exp_q.size() != 0) begin
            $display("%0d expected reports never arrived", exp_q.size());
            err_count++;
        end
        $display("errors: %0d, reports checked: %0d", err_count, report_count);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
verilog/commit_pkg.sv
verilog/rob_head_if.sv
verilog/commit_wb_if.sv
verilog/reorder_buffer.sv
verilog/commit_decoder.sv
verilog/commit_logic.sv
verilog/arch_regfile.sv
verilog/commit_top.sv
verification/tb_commit_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the retirement stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --Wno-fatal -f verilog.f --top-module tb_commit_top -o tb_commit_top \
    && ./obj_dir/tb_commit_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log \
    && echo "simulation run ok" \
    || { echo "simulation run not ok"; exit 1; }
